/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = fetch_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_TEXT = All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/clk_gen.sv */
`timescale 1ns/10ps

module clk_gen #(
    // Half of the 4 ns period
    parameter int HALF_PERIOD = 2
) (
    output logic clk
);

    // Free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule

/* sim/fetch_checker.sv */
`timescale 1ns/10ps
`include "fetch_defs.svh"

module fetch_checker
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  logic  load_valid,
    input  word_t load_data,
    input  logic  load_last,
    input  logic  step,
    input  logic  jump,
    input  addr_t jump_addr,
    input  logic  run,
    input  addr_t pc,
    input  word_t instr,
    input  logic  err,
    output int    error_count
);

    // Model of controller state, pointer and memory image
    boot_state_e st_model;
    addr_t       pc_model;
    logic [7:0]  mem_model [0:`FETCH_MEM_BYTES-1];
    // Expected {err, instr} for the current model pc
    logic [32:0] expected;
    int          fails = 0;

    // Expected {err, instr} for a fetch at byte address a
    function automatic logic [32:0] ref_fetch(input addr_t a);
        logic [32:0] res;
        res = '0;
        if (a[1:0] != 2'b00) begin
            // Misaligned fetch reads zero and flags it
            res[32] = 1'b1;
        end else begin
            // Little endian, byte 0 is bits 7:0
            for (int b = 0; b < 4; b++) begin
                res[8*b +: 8] = mem_model[a + addr_t'(b)];
            end
        end
        return res;
    endfunction

    ////////////////////
    // Compare, then step the model
    ////////////////////

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_model = BOOT_IDLE;
            pc_model = '0;
            for (int i = 0; i < `FETCH_MEM_BYTES; i++) begin
                mem_model[i] = 8'h00;
            end
        end else begin
            // DUT outputs still hold their pre-edge values here
            expected = ref_fetch(pc_model);
            if (pc !== pc_model) begin
                $display("CHECK FAILED at %0t: pc is %h, expected %h", $time, pc, pc_model);
                fails++;
            end
            if (run !== (st_model == BOOT_RUN)) begin
                $display("CHECK FAILED at %0t: run is %b in state %s", $time, run,
                         st_model.name());
                fails++;
            end
            if (instr !== expected[31:0]) begin
                $display("CHECK FAILED at %0t: instr at %h is %h, expected %h", $time,
                         pc_model, instr, expected[31:0]);
                fails++;
            end
            if (err !== expected[32]) begin
                $display("CHECK FAILED at %0t: err at %h is %b, expected %b", $time,
                         pc_model, err, expected[32]);
                fails++;
            end
            case (st_model)
                BOOT_IDLE: begin
                    if (start) begin
                        st_model = BOOT_LOAD;
                    end
                end
                BOOT_LOAD: begin
                    if (load_valid) begin
                        // Words running past the top of memory are dropped
                        if (int'(pc_model) + 3 < `FETCH_MEM_BYTES) begin
                            for (int b = 0; b < 4; b++) begin
                                mem_model[pc_model + addr_t'(b)] = load_data[8*b +: 8];
                            end
                        end
                        if (load_last) begin
                            st_model = BOOT_RUN;
                            pc_model = '0;
                        end else begin
                            pc_model = pc_model + addr_t'(4);
                        end
                    end
                end
                BOOT_RUN: begin
                    // jump wins over step
                    if (jump) begin
                        pc_model = jump_addr;
                    end else if (step) begin
                        pc_model = pc_model + addr_t'(4);
                    end
                end
                default: begin
                    st_model = BOOT_IDLE;
                end
            endcase
        end
    end

    assign error_count = fails;

endmodule

/* sim/fetch_tb.sv */
`timescale 1ns/10ps

module fetch_tb
    import fetch_pkg::*;
();

    localparam int NUM_WORDS   = 40;
    localparam int RUN_TIMEOUT = 20;

    logic  clk;
    logic  rst_n;
    logic  start;
    logic  load_valid;
    word_t load_data;
    logic  load_last;
    logic  step;
    logic  jump;
    addr_t jump_addr;
    logic  run;
    addr_t pc;
    word_t instr;
    logic  err;
    int    chk_errors;

    // Stimulus and score bookkeeping
    int    seed = 45;
    int    tb_errors = 0;
    int    tests_done = 0;
    int    tests_failed = 0;
    int    errors_seen = 0;
    // Words written by the current load, in address order
    word_t words[$];

    clk_gen u_clk_gen (.clk(clk));

    fetch_top dut0 (.*);

    fetch_checker u_checker (.*, .error_count(chk_errors));

    ////////////////////
    // Helper tasks
    ////////////////////

    // Idle every input and hold reset over two rising edges
    task automatic apply_reset();
        rst_n      = 1'b0;
        start      = 1'b0;
        load_valid = 1'b0;
        load_data  = '0;
        load_last  = 1'b0;
        step       = 1'b0;
        jump       = 1'b0;
        jump_addr  = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic expect_value(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            tb_errors++;
        end
    endtask

    // One line per test, failed if it added any errors
    task automatic finish_test(input string name);
        int now_errors;
        now_errors = tb_errors + chk_errors;
        tests_done++;
        if (now_errors != errors_seen) begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_done, name,
                     now_errors - errors_seen);
        end else begin
            $display("test %0d %s: ok", tests_done, name);
        end
        errors_seen = now_errors;
    endtask

    // Single-cycle jump strobe
    task automatic do_jump(input addr_t target);
        jump      = 1'b1;
        jump_addr = target;
        @(negedge clk);
        jump = 1'b0;
    endtask

    // Pulse start, stream n random words, then wait for run
    task automatic load_image(input int n);
        int wait_cycles;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        for (int i = 0; i < n; i++) begin
            load_valid = 1'b1;
            load_data  = $random(seed);
            load_last  = (i == n - 1);
            words.push_back(load_data);
            @(negedge clk);
        end
        load_valid = 1'b0;
        load_last  = 1'b0;
        wait_cycles = 0;
        while (!run && wait_cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!run) begin
            $display("Timeout: run never went high after the last word");
            tb_errors++;
        end
    endtask

    // Jump to 0, step over the image and then over blank words after it
    task automatic read_back(input int n, input int blank);
        do_jump('0);
        for (int i = 0; i < n + blank; i++) begin
            expect_value(32'(pc), 32'(4 * i), "pc");
            expect_value(instr, (i < n) ? words[i] : '0, "instr");
            step = 1'b1;
            @(negedge clk);
        end
        step = 1'b0;
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        apply_reset();
        expect_value(32'(run), 32'd0, "run after reset");
        expect_value(32'(pc), 32'd0, "pc after reset");
        expect_value(instr, 32'd0, "instr after reset");
        expect_value(32'(err), 32'd0, "err after reset");
        finish_test("reset state");

        load_image(NUM_WORDS);
        read_back(NUM_WORDS, 4);
        finish_test("load and step");

        // Step on from the jump target, then jump and step together
        do_jump(addr_t'(4 * 17));
        expect_value(instr, words[17], "instr after jump");
        step = 1'b1;
        @(negedge clk);
        step = 1'b0;
        expect_value(instr, words[18], "instr after step");
        step = 1'b1;
        do_jump(addr_t'(4 * 5));
        step = 1'b0;
        expect_value(32'(pc), 32'd20, "pc after jump with step");
        expect_value(instr, words[5], "instr after jump with step");
        finish_test("jump");

        do_jump(addr_t'(4 * 3 + 2));
        expect_value(32'(err), 32'd1, "err on misaligned pc");
        expect_value(instr, 32'd0, "instr on misaligned pc");
        do_jump(addr_t'(4 * 9));
        expect_value(32'(err), 32'd0, "err after realign");
        expect_value(instr, words[9], "instr after realign");
        finish_test("misaligned jump");

        // Loader noise while running must not touch memory
        for (int i = 0; i < 30; i++) begin
            start      = 1'($random(seed));
            load_valid = 1'($random(seed));
            load_data  = $random(seed);
            @(negedge clk);
        end
        start      = 1'b0;
        load_valid = 1'b0;
        read_back(NUM_WORDS, 0);
        finish_test("run mode write guard");

        apply_reset();
        words.delete();
        // Strobes before start go nowhere
        for (int i = 0; i < 4; i++) begin
            load_valid = 1'b1;
            load_data  = $random(seed);
            @(negedge clk);
        end
        load_valid = 1'b0;
        expect_value(32'(run), 32'd0, "run before start");
        expect_value(instr, 32'd0, "instr after early strobes");
        load_image(4);
        read_back(4, 8);
        finish_test("second reset");

        $display("%0d tests, %0d failed, %0d errors", tests_done, tests_failed,
                 tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* source/boot_ctrl.sv */
`timescale 1ns/10ps

module boot_ctrl
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  logic  load_valid,
    input  word_t load_data,
    input  logic  load_last,
    input  logic  step,
    input  logic  jump,
    input  addr_t jump_addr,
    input  addr_t count,
    output logic  clear,
    output logic  advance,
    output logic  load,
    output addr_t load_addr,
    output logic  run,
    imem_if.ctrl  mem
);

    boot_state_e state_q;
    boot_state_e state_d;

    ////////////////////
    // State register
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= BOOT_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////
    // Next state and counter control
    ////////////////////

    always_comb begin
        state_d    = state_q;
        clear      = 1'b0;
        advance    = 1'b0;
        load       = 1'b0;
        mem.wr_en  = 1'b0;
        case (state_q)
            BOOT_IDLE: begin
                // Loader strobes are ignored until start
                if (start) begin
                    state_d = BOOT_LOAD;
                end
            end
            BOOT_LOAD: begin
                // Write at the pointer and bump it in the same cycle
                mem.wr_en = load_valid;
                advance   = load_valid;
                if (load_valid && load_last) begin
                    // Clear overrides the advance in the counter
                    clear   = 1'b1;
                    state_d = BOOT_RUN;
                end
            end
            BOOT_RUN: begin
                // Memory is frozen from here on
                advance = step;
                load    = jump;
            end
            default: begin
                state_d = BOOT_IDLE;
            end
        endcase
    end

    // Only consumed when load is raised
    assign load_addr = jump_addr;

    // Counter doubles as write pointer and fetch address
    assign mem.wr_addr = count;
    assign mem.wr_data = load_data;
    assign mem.rd_addr = count;

    assign run = (state_q == BOOT_RUN);

endmodule

/* source/fetch_defs.svh */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Byte address width of the instruction memory
`define FETCH_ADDR_W 10

// Instruction word width
`define FETCH_WORD_W 32

// One byte per address over the whole address space
`define FETCH_MEM_BYTES (1 << `FETCH_ADDR_W)

`endif

/* source/fetch_pkg.sv */
`include "fetch_defs.svh"

package fetch_pkg;

    ////////////////////
    // Data types
    ////////////////////

    // Byte address into instruction memory
    typedef logic [`FETCH_ADDR_W-1:0] addr_t;

    // One instruction word
    typedef logic [`FETCH_WORD_W-1:0] word_t;

    ////////////////////
    // Boot sequencing
    ////////////////////

    // Idle until start, then load the image, then fetch
    typedef enum logic [1:0] {
        BOOT_IDLE = 2'd0,
        BOOT_LOAD = 2'd1,
        BOOT_RUN  = 2'd2
    } boot_state_e;

endpackage

/* source/fetch_top.sv */
`timescale 1ns/10ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    // Boot and loader strobes
    input  logic  start,
    input  logic  load_valid,
    input  word_t load_data,
    input  logic  load_last,
    // Fetch control from the core
    input  logic  step,
    input  logic  jump,
    input  addr_t jump_addr,
    // Fetch results
    output logic  run,
    output addr_t pc,
    output word_t instr,
    output logic  err
);

    // Counter control from the controller
    logic  clear;
    logic  advance;
    logic  load;
    addr_t load_addr;
    addr_t count;

    // Write and read ports between controller and memory
    imem_if imem ();

    ////////////////////
    // Instances
    ////////////////////

    boot_ctrl u_boot_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .load_valid (load_valid),
        .load_data  (load_data),
        .load_last  (load_last),
        .step       (step),
        .jump       (jump),
        .jump_addr  (jump_addr),
        .count      (count),
        .clear      (clear),
        .advance    (advance),
        .load       (load),
        .load_addr  (load_addr),
        .run        (run),
        .mem        (imem.ctrl)
    );

    pc_counter u_pc_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .advance    (advance),
        .load       (load),
        .load_addr  (load_addr),
        .count      (count)
    );

    instr_mem u_instr_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem        (imem.mem)
    );

    // Fetch outputs straight off the counter and memory
    assign pc    = count;
    assign instr = imem.rd_data;
    assign err   = imem.rd_err;

endmodule

/* source/imem_if.sv */
`timescale 1ns/10ps

interface imem_if
    import fetch_pkg::*;
();

    // Write port used only while the image is loaded
    logic  wr_en;
    addr_t wr_addr;
    word_t wr_data;

    // Read port for instruction fetch
    addr_t rd_addr;
    word_t rd_data;
    // High for an address that is not word aligned
    logic  rd_err;

    // Controller side
    modport ctrl (
        output wr_en,
        output wr_addr,
        output wr_data,
        output rd_addr
    );

    // Memory side
    modport mem (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        output rd_data,
        output rd_err
    );

endinterface

/* source/instr_mem.sv */
`timescale 1ns/10ps
`include "fetch_defs.svh"

module instr_mem
    import fetch_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    imem_if.mem    mem
);

    // Bytes making up one instruction word
    localparam int WORD_BYTES = `FETCH_WORD_W / 8;

    // Highest byte address, one bit wider so the end sum cannot wrap
    localparam logic [`FETCH_ADDR_W:0] TOP_ADDR = `FETCH_MEM_BYTES - 1;

    // Byte storage
    logic [7:0] mem_array [0:`FETCH_MEM_BYTES-1];

    // Last byte address touched by a write
    logic [`FETCH_ADDR_W:0] wr_end;
    logic                   wr_in_range;
    logic                   rd_aligned;

    ////////////////////
    // Write side
    ////////////////////

    // Word must fit entirely below the top of memory
    assign wr_end      = {1'b0, mem.wr_addr} + (`FETCH_ADDR_W+1)'(WORD_BYTES - 1);
    assign wr_in_range = (wr_end <= TOP_ADDR);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Whole image is cleared on reset
            for (int i = 0; i < `FETCH_MEM_BYTES; i++) begin
                mem_array[i] <= 8'h00;
            end
        end else if (mem.wr_en && wr_in_range) begin
            // Little endian, lowest byte at the lowest address
            for (int b = 0; b < WORD_BYTES; b++) begin
                mem_array[mem.wr_addr + addr_t'(b)] <= mem.wr_data[8*b +: 8];
            end
        end
    end

    ////////////////////
    // Read side
    ////////////////////

    // Fetch addresses must be multiples of 4
    assign rd_aligned = (mem.rd_addr[1:0] == 2'b00);
    assign mem.rd_err = !rd_aligned;

    // Same-cycle read, misaligned fetch returns zero
    always_comb begin
        mem.rd_data = '0;
        if (rd_aligned) begin
            // Aligned word never crosses the top of memory
            for (int b = 0; b < WORD_BYTES; b++) begin
                mem.rd_data[8*b +: 8] = mem_array[mem.rd_addr + addr_t'(b)];
            end
        end
    end

endmodule

/* source/pc_counter.sv */
`timescale 1ns/10ps

module pc_counter
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clear,
    input  logic  advance,
    input  logic  load,
    input  addr_t load_addr,
    output addr_t count
);

    // Distance between consecutive words
    localparam addr_t WORD_STEP = addr_t'(4);

    addr_t count_q;

    // Write pointer during load, program counter during run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (clear) begin
            // Rewind to address 0 at the load to run switch
            count_q <= '0;
        end else if (load) begin
            // Jump target wins over a step
            count_q <= load_addr;
        end else if (advance) begin
            // Wraps at the top of the address space
            count_q <= count_q + WORD_STEP;
        end
    end

    assign count = count_q;

endmodule

/* tb.f */
+incdir+source
source/fetch_pkg.sv
source/imem_if.sv
source/instr_mem.sv
source/pc_counter.sv
source/boot_ctrl.sv
source/fetch_top.sv
sim/clk_gen.sv
sim/fetch_checker.sv
sim/fetch_tb.sv
